//--- fetch_pkg.sv
package fetch_pkg;

    // canonical LoongArch nop, andi r0,r0,0
    localparam logic [31:0] inst_nop = 32'h03400000;

    // first fetch address after reset
    localparam logic [31:0] pc_reset = 32'h1c000000;

    // number of fetch packets the buffer holds unless the top says otherwise
    localparam int buf_depth_default = 64;

    // the two instructions of one fetch packet, inst0 sits at pc
    typedef struct packed {
        logic [31:0] inst0;
        logic [31:0] inst1;
    } inst_pair_t;

    // address group of a packet
    typedef struct packed {
        logic [31:0] pc_next;
        logic [31:0] pc;
        logic [31:0] badv;
    } pc_group_t;

    // status bits, 45 in total, branch_flag is the most significant field
    typedef struct packed {
        logic [1:0]  branch_flag;
        logic [1:0]  priv_flag;
        logic [1:0]  excp_flag;
        logic [6:0]  exception;
        logic [31:0] cookie;
    } stat_t;

endpackage

//--- fetch_out_if.sv
`timescale 1ns/1ps

// head packet of the fetch buffer on its way to predecode
// a packet moves when valid and ready are both high at a rising edge
interface fetch_out_if;

    logic                   valid;
    logic                   ready;
    fetch_pkg::inst_pair_t  pair;
    fetch_pkg::pc_group_t   pcs;
    fetch_pkg::stat_t       stat;

    // the buffer presents the packet and listens to ready
    modport buf_side (
        output valid,
        output pair,
        output pcs,
        output stat,
        input  ready
    );

    // predecode takes the packet and answers with ready
    modport dec_side (
        input  valid,
        input  pair,
        input  pcs,
        input  stat,
        output ready
    );

endinterface

//--- fifo_store.sv
`timescale 1ns/1ps

// circular queue, registered write and flags, head entry read combinationally
module fifo_store #(
    parameter type payload_t     = logic [31:0],
    parameter int  depth         = fetch_pkg::buf_depth_default,
    parameter int  nearly_margin = 1
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     write_en,
    input  logic     pop_en,
    input  payload_t din,
    output payload_t dout,
    output logic     empty,
    output logic     full,
    output logic     nearly_full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t           mem [0:depth-1];
    logic [ptr_w-1:0]   head;
    logic [ptr_w-1:0]   tail;
    logic [cnt_w-1:0]   count;
    logic [cnt_w-1:0]   count_next;

    // wrap explicitly so depths that are not a power of two also work
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    always_comb begin
        count_next = count;
        if (flush) begin
            count_next = '0;
        end else if (write_en && !pop_en) begin
            count_next = count + 1'b1;
        end else if (pop_en && !write_en) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            empty <= 1'b1;
            full  <= 1'b0;
        end else begin
            count <= count_next;
            empty <= (count_next == '0);
            full  <= (count_next == cnt_w'(depth));
            if (flush) begin
                head <= '0;
                tail <= '0;
            end else begin
                if (write_en)
                    tail <= next_ptr(tail);
                if (pop_en)
                    head <= next_ptr(head);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_en && !flush)
            mem[tail] <= din;
    end

    assign dout        = mem[head];
    assign nearly_full = (cnt_w'(depth) - count) <= cnt_w'(nearly_margin);

    // the owner must gate its enables with the flags it gets back
    assert property (@(posedge clk) disable iff (reset) !(pop_en && empty))
        else $error("fifo_store: pop while empty");
    assert property (@(posedge clk) disable iff (reset) !(write_en && full))
        else $error("fifo_store: write while full");

endmodule

//--- fetch_buffer.sv
`timescale 1ns/1ps

// fetch packet buffer, three stores that move in lock step
module fetch_buffer #(
    parameter int depth         = fetch_pkg::buf_depth_default,
    parameter int nearly_margin = 1
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        push,
    input  logic [31:0] inst0,
    input  logic [31:0] inst1,
    input  logic [31:0] pc,
    input  logic [31:0] pc_next,
    input  logic [31:0] badv,
    input  logic [31:0] cookie,
    input  logic [6:0]  exception,
    input  logic [1:0]  excp_flag,
    input  logic [1:0]  priv_flag,
    input  logic [1:0]  branch_flag,
    output logic        allowin,
    output logic        nearly_full,
    fetch_out_if.buf_side out_port
);

    // packet shown to decode while nothing is buffered
    localparam fetch_pkg::inst_pair_t pair_default = '{
        inst0: fetch_pkg::inst_nop,
        inst1: fetch_pkg::inst_nop
    };
    localparam fetch_pkg::pc_group_t pcs_default = '{
        pc_next: fetch_pkg::pc_reset + 32'd8,
        pc:      fetch_pkg::pc_reset,
        badv:    fetch_pkg::pc_reset
    };

    fetch_pkg::inst_pair_t  pair_din, pair_dout;
    fetch_pkg::pc_group_t   pcs_din, pcs_dout;
    fetch_pkg::stat_t       stat_din, stat_dout;
    logic                   empty, full;
    logic                   pcs_empty, pcs_full, pcs_nearly;
    logic                   stat_empty, stat_full, stat_nearly;
    logic                   write_en, pop_en;

    assign pair_din = '{inst0: inst0, inst1: inst1};
    assign pcs_din  = '{pc_next: pc_next, pc: pc, badv: badv};
    assign stat_din = '{branch_flag: branch_flag, priv_flag: priv_flag,
                        excp_flag: excp_flag, exception: exception, cookie: cookie};

    // a push into a full buffer is simply lost here
    assign write_en = push && !full;
    assign pop_en   = out_port.ready && !empty;
    assign allowin  = !full;

    assign out_port.valid = !empty;
    assign out_port.pair  = empty ? pair_default : pair_dout;
    assign out_port.pcs   = empty ? pcs_default : pcs_dout;
    assign out_port.stat  = empty ? '0 : stat_dout;

    fifo_store #(.payload_t(fetch_pkg::inst_pair_t), .depth(depth),
                 .nearly_margin(nearly_margin)) u_pair_store (
        .clk(clk), .reset(reset), .flush(flush),
        .write_en(write_en), .pop_en(pop_en), .din(pair_din), .dout(pair_dout),
        .empty(empty), .full(full), .nearly_full(nearly_full)
    );

    fifo_store #(.payload_t(fetch_pkg::pc_group_t), .depth(depth),
                 .nearly_margin(nearly_margin)) u_pcs_store (
        .clk(clk), .reset(reset), .flush(flush),
        .write_en(write_en), .pop_en(pop_en), .din(pcs_din), .dout(pcs_dout),
        .empty(pcs_empty), .full(pcs_full), .nearly_full(pcs_nearly)
    );

    fifo_store #(.payload_t(fetch_pkg::stat_t), .depth(depth),
                 .nearly_margin(nearly_margin)) u_stat_store (
        .clk(clk), .reset(reset), .flush(flush),
        .write_en(write_en), .pop_en(pop_en), .din(stat_din), .dout(stat_dout),
        .empty(stat_empty), .full(stat_full), .nearly_full(stat_nearly)
    );

    // only the pair store's flags steer the enables, the others must track it
    assert property (@(posedge clk) disable iff (reset)
        (empty == pcs_empty) && (empty == stat_empty) &&
        (full == pcs_full) && (full == stat_full) &&
        (nearly_full == pcs_nearly) && (nearly_full == stat_nearly))
        else $error("fetch_buffer: stores out of step");

endmodule

//--- inst_predecode.sv
`timescale 1ns/1ps

// light predecode of the head packet, purely combinational
module inst_predecode (
    fetch_out_if.dec_side in_port,
    input  logic        ready,
    output logic        valid,
    output logic [31:0] inst0,
    output logic [31:0] inst1,
    output logic [31:0] pc,
    output logic [31:0] pc_add4,
    output logic [31:0] pc_next,
    output logic [31:0] badv,
    output logic [31:0] cookie,
    output logic [6:0]  exception,
    output logic [1:0]  excp_flag,
    output logic [1:0]  priv_flag,
    output logic [1:0]  branch_flag,
    output logic        is_branch0,
    output logic        is_branch1,
    output logic        is_nop0,
    output logic        is_nop1
);

    // opcodes 010011 to 011011 hold jirl, b, bl and the six conditional branches
    function automatic logic branch_op(input logic [31:0] inst);
        return (inst[31:26] >= 6'b010011) && (inst[31:26] <= 6'b011011);
    endfunction

    assign in_port.ready = ready;
    assign valid         = in_port.valid;

    assign inst0       = in_port.pair.inst0;
    assign inst1       = in_port.pair.inst1;
    assign pc          = in_port.pcs.pc;
    assign pc_next     = in_port.pcs.pc_next;
    assign badv        = in_port.pcs.badv;
    assign cookie      = in_port.stat.cookie;
    assign exception   = in_port.stat.exception;
    assign excp_flag   = in_port.stat.excp_flag;
    assign priv_flag   = in_port.stat.priv_flag;
    assign branch_flag = in_port.stat.branch_flag;

    // inst1 lives one word after inst0
    assign pc_add4 = in_port.pcs.pc + 32'd4;

    // the default packet is two nops, so the flags are masked with valid
    assign is_branch0 = valid && branch_op(inst0);
    assign is_branch1 = valid && branch_op(inst1);
    assign is_nop0    = valid && (inst0 == fetch_pkg::inst_nop);
    assign is_nop1    = valid && (inst1 == fetch_pkg::inst_nop);

endmodule

//--- fetch_queue_top.sv
`timescale 1ns/1ps

// fetch buffer followed by predecode, between fetch stage one and decode
module fetch_queue_top #(
    parameter int depth         = fetch_pkg::buf_depth_default,
    parameter int nearly_margin = 1
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        push,
    input  logic [31:0] fetch_inst0,
    input  logic [31:0] fetch_inst1,
    input  logic [31:0] fetch_pc,
    input  logic [31:0] fetch_pc_next,
    input  logic [31:0] fetch_badv,
    input  logic [31:0] fetch_cookie,
    input  logic [6:0]  fetch_exception,
    input  logic [1:0]  fetch_excp_flag,
    input  logic [1:0]  fetch_priv_flag,
    input  logic [1:0]  fetch_branch_flag,
    output logic        allowin,
    output logic        nearly_full,
    input  logic        ready,
    output logic        valid,
    output logic [31:0] inst0,
    output logic [31:0] inst1,
    output logic [31:0] pc,
    output logic [31:0] pc_add4,
    output logic [31:0] pc_next,
    output logic [31:0] badv,
    output logic [31:0] cookie,
    output logic [6:0]  exception,
    output logic [1:0]  excp_flag,
    output logic [1:0]  priv_flag,
    output logic [1:0]  branch_flag,
    output logic        is_branch0,
    output logic        is_branch1,
    output logic        is_nop0,
    output logic        is_nop1
);

    fetch_out_if head_link ();

    fetch_buffer #(
        .depth         (depth),
        .nearly_margin (nearly_margin)
    ) u_fetch_buffer (
        .clk(clk), .reset(reset), .flush(flush), .push(push),
        .inst0(fetch_inst0), .inst1(fetch_inst1),
        .pc(fetch_pc), .pc_next(fetch_pc_next), .badv(fetch_badv),
        .cookie(fetch_cookie), .exception(fetch_exception),
        .excp_flag(fetch_excp_flag), .priv_flag(fetch_priv_flag),
        .branch_flag(fetch_branch_flag),
        .allowin(allowin), .nearly_full(nearly_full),
        .out_port(head_link.buf_side)
    );

    inst_predecode u_inst_predecode (
        .in_port(head_link.dec_side), .ready(ready), .valid(valid),
        .inst0(inst0), .inst1(inst1), .pc(pc), .pc_add4(pc_add4),
        .pc_next(pc_next), .badv(badv), .cookie(cookie),
        .exception(exception), .excp_flag(excp_flag),
        .priv_flag(priv_flag), .branch_flag(branch_flag),
        .is_branch0(is_branch0), .is_branch1(is_branch1),
        .is_nop0(is_nop0), .is_nop1(is_nop1)
    );

endmodule

//--- tb_fetch_queue.sv
`timescale 1ns/1ps

// testbench for the fetch queue, checked against a queue model of the expected packets
module tb_fetch_queue;

    localparam int depth = 8;
    localparam int margin = 1;
    localparam int idle_cycles = 6;
    localparam int rand_cycles = 300;
    localparam int drain_limit = 2 * depth + 8;
    // reset, every phase and four drains
    localparam int run_cycles = 4 + idle_cycles + rand_cycles + depth + 3 + 9 + 16
                                + 4 * (drain_limit + 3) + 2;

    typedef struct packed {
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] badv;
        logic [31:0] cookie;
        logic [6:0]  exception;
        logic [1:0]  excp_flag;
        logic [1:0]  priv_flag;
        logic [1:0]  branch_flag;
    } pkt_t;

    localparam pkt_t default_pkt = '{
        inst0: fetch_pkg::inst_nop, inst1: fetch_pkg::inst_nop,
        pc: fetch_pkg::pc_reset, pc_next: fetch_pkg::pc_reset + 32'd8,
        badv: fetch_pkg::pc_reset, cookie: '0, exception: '0,
        excp_flag: '0, priv_flag: '0, branch_flag: '0
    };

    logic        clk, reset, flush, push, ready;
    pkt_t        drv;
    logic        valid, allowin, nearly_full;
    logic [31:0] inst0, inst1, pc, pc_add4, pc_next, badv, cookie;
    logic [6:0]  exception;
    logic [1:0]  excp_flag, priv_flag, branch_flag;
    logic        is_branch0, is_branch1, is_nop0, is_nop1;

    pkt_t        model_q[$];
    pkt_t        exp_head;
    logic        exp_valid;
    int          exp_count;
    bit          room;
    logic [31:0] lfsr = 32'hc908;
    int          errors = 0;
    int          tests = 0;
    int          mark = 0;

    fetch_queue_top #(.depth(depth), .nearly_margin(margin)) uut (
        .clk(clk), .reset(reset), .flush(flush), .push(push),
        .fetch_inst0(drv.inst0), .fetch_inst1(drv.inst1), .fetch_pc(drv.pc),
        .fetch_pc_next(drv.pc_next), .fetch_badv(drv.badv), .fetch_cookie(drv.cookie),
        .fetch_exception(drv.exception), .fetch_excp_flag(drv.excp_flag),
        .fetch_priv_flag(drv.priv_flag), .fetch_branch_flag(drv.branch_flag),
        .allowin(allowin), .nearly_full(nearly_full), .ready(ready), .valid(valid),
        .inst0(inst0), .inst1(inst1), .pc(pc), .pc_add4(pc_add4), .pc_next(pc_next),
        .badv(badv), .cookie(cookie), .exception(exception), .excp_flag(excp_flag),
        .priv_flag(priv_flag), .branch_flag(branch_flag),
        .is_branch0(is_branch0), .is_branch1(is_branch1),
        .is_nop0(is_nop0), .is_nop1(is_nop1)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci lfsr with taps 32, 22, 2 and 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // a quarter of the words become nops, a quarter get an opcode around the branch range
    function automatic logic [31:0] shape_inst(input logic [31:0] w);
        logic [31:0] r;
        logic [1:0]  sel;
        r = w;
        sel = 2'(rand_bits(2));
        if (sel == 2'd0)
            r = fetch_pkg::inst_nop;
        else if (sel == 2'd1)
            r[31:26] = 6'h12 + 6'(rand_bits(4));
        return r;
    endfunction

    function automatic pkt_t random_packet();
        pkt_t p;
        p.inst0 = shape_inst(rand_bits(32));
        p.inst1 = shape_inst(rand_bits(32));
        p.pc = rand_bits(30) << 2;
        p.pc_next = p.pc + 32'd8;
        p.badv = rand_bits(32);
        p.cookie = rand_bits(32);
        p.exception = 7'(rand_bits(7));
        p.excp_flag = 2'(rand_bits(2));
        p.priv_flag = 2'(rand_bits(2));
        p.branch_flag = 2'(rand_bits(2));
        return p;
    endfunction

    // jirl, b, bl and the conditional branches sit at opcodes 0x13 to 0x1b
    function automatic logic [3:0] expected_flags(input logic v, input pkt_t p);
        logic b0, b1;
        b0 = (p.inst0[31:26] >= 6'h13) && (p.inst0[31:26] <= 6'h1b);
        b1 = (p.inst1[31:26] >= 6'h13) && (p.inst1[31:26] <= 6'h1b);
        return {v && b0, v && b1, v && (p.inst0 == fetch_pkg::inst_nop),
                v && (p.inst1 == fetch_pkg::inst_nop)};
    endfunction

    function automatic void report_mismatch(input string name, input logic [63:0] got,
                                            input logic [63:0] exp);
        errors++;
        $display("ERROR %0s got %0h expected %0h", name, got, exp);
    endfunction

    // the model sees the same pre-edge inputs as the DUT
    always @(posedge clk) begin
        room = model_q.size() < depth;
        if (reset || flush) begin
            model_q.delete();
        end else begin
            if (ready && model_q.size() != 0)
                void'(model_q.pop_front());
            if (push && room)
                model_q.push_back(drv);
        end
        exp_count <= model_q.size();
        exp_valid <= model_q.size() != 0;
        exp_head <= (model_q.size() != 0) ? model_q[0] : default_pkt;
    end

    assert property (@(posedge clk) disable iff (reset) valid == exp_valid)
        else report_mismatch("valid", 64'(valid), 64'(exp_valid));
    assert property (@(posedge clk) disable iff (reset) inst0 == exp_head.inst0)
        else report_mismatch("inst0", 64'(inst0), 64'(exp_head.inst0));
    assert property (@(posedge clk) disable iff (reset) inst1 == exp_head.inst1)
        else report_mismatch("inst1", 64'(inst1), 64'(exp_head.inst1));
    assert property (@(posedge clk) disable iff (reset) pc == exp_head.pc)
        else report_mismatch("pc", 64'(pc), 64'(exp_head.pc));
    assert property (@(posedge clk) disable iff (reset) pc_next == exp_head.pc_next)
        else report_mismatch("pc_next", 64'(pc_next), 64'(exp_head.pc_next));
    assert property (@(posedge clk) disable iff (reset) badv == exp_head.badv)
        else report_mismatch("badv", 64'(badv), 64'(exp_head.badv));
    assert property (@(posedge clk) disable iff (reset)
        {branch_flag, priv_flag, excp_flag, exception, cookie} ==
        {exp_head.branch_flag, exp_head.priv_flag, exp_head.excp_flag,
         exp_head.exception, exp_head.cookie})
        else report_mismatch("status", 64'({branch_flag, priv_flag, excp_flag,
            exception, cookie}), 64'({exp_head.branch_flag, exp_head.priv_flag,
            exp_head.excp_flag, exp_head.exception, exp_head.cookie}));
    assert property (@(posedge clk) disable iff (reset) pc_add4 == exp_head.pc + 32'd4)
        else report_mismatch("pc_add4", 64'(pc_add4), 64'(exp_head.pc + 32'd4));
    assert property (@(posedge clk) disable iff (reset)
        {is_branch0, is_branch1, is_nop0, is_nop1} == expected_flags(exp_valid, exp_head))
        else report_mismatch("predecode flags", 64'({is_branch0, is_branch1, is_nop0,
            is_nop1}), 64'(expected_flags(exp_valid, exp_head)));
    assert property (@(posedge clk) disable iff (reset) allowin == (exp_count < depth))
        else report_mismatch("allowin", 64'(allowin), 64'(exp_count < depth));
    assert property (@(posedge clk) disable iff (reset)
        nearly_full == ((depth - exp_count) <= margin))
        else report_mismatch("nearly_full", 64'(nearly_full),
            64'((depth - exp_count) <= margin));

    task automatic push_cycles(input int n, input logic rdy);
        repeat (n) begin
            @(posedge clk);
            flush <= 1'b0;
            push <= 1'b1;
            ready <= rdy;
            drv <= random_packet();
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        @(posedge clk);
        flush <= 1'b0;
        push <= 1'b0;
        ready <= 1'b1;
        repeat (2) @(posedge clk);
        while (valid && n < drain_limit) begin
            @(posedge clk);
            n++;
        end
        if (valid) begin
            errors++;
            $display("drain: valid still high after %0d cycles with ready held", n);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == mark)
            $display("test %0s: ok", name);
        else
            $display("test %0s: %0d failed checks", name, errors - mark);
        mark = errors;
    endtask

    initial begin
        pkt_t p;
        reset <= 1'b1;
        flush <= 1'b0;
        push <= 1'b0;
        ready <= 1'b0;
        drv <= default_pkt;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        repeat (idle_cycles) @(posedge clk);
        end_test("empty after reset");

        repeat (rand_cycles) begin
            @(posedge clk);
            push <= rand_bits(2) != 0;
            ready <= rand_bits(1) != 0;
            drv <= random_packet();
        end
        drain();
        end_test("random push and ready");

        // more pushes than slots while decode stalls, the extra ones are dropped
        push_cycles(depth + 3, 1'b0);
        drain();
        end_test("fill with ready low");

        // the push that shares the flush cycle is lost as well
        push_cycles(5, 1'b0);
        @(posedge clk);
        flush <= 1'b1;
        drv <= random_packet();
        push_cycles(3, 1'b0);
        drain();
        end_test("flush with traffic");

        for (int op = 16; op < 32; op++) begin
            p = random_packet();
            p.inst0[31:26] = 6'(op);
            p.inst1[31:26] = 6'(47 - op);
            @(posedge clk);
            push <= 1'b1;
            ready <= 1'b1;
            drv <= p;
        end
        drain();
        end_test("opcode sweep");

        repeat (2) @(posedge clk);
        $display("tests run: %0d, failed checks: %0d", tests, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial begin
        #((run_cycles + 50) * 10);
        $display("watchdog: run did not end within %0d cycles", run_cycles + 50);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- project.f
fetch_pkg.sv
fetch_out_if.sv
fifo_store.sv
fetch_buffer.sv
inst_predecode.sv
fetch_queue_top.sv
tb_fetch_queue.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_queue
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
